// File: source/mem_hub_pkg.sv
// Widths, timer register addresses and arbiter states shared by every block of the memory hub

package mem_hub_pkg;

    // byte address on every port
    typedef logic [63:0] addr_t;

    // data word for RAM and timer, always written whole
    typedef logic [63:0] word_t;

    // instruction word returned to the fetch port
    typedef logic [31:0] inst_t;

    // request source tag carried through the queue
    typedef logic src_t;

    localparam src_t SRC_INST = 1'b0;
    localparam src_t SRC_DATA = 1'b1;

    // machine timer registers, decoded away from the RAM port
    localparam addr_t MTIME_ADDR    = 64'h0000_0000_0200_BFF8;
    localparam addr_t MTIMECMP_ADDR = 64'h0000_0000_0200_4000;

    // per-port state of the four-phase handshake
    typedef enum logic [1:0] {
        PORT_IDLE   = 2'd0,
        PORT_QUEUED = 2'd1,
        PORT_ACK    = 2'd2
    } port_state_e;

endpackage

// File: source/clint_timer.sv
// Free-running 64-bit mtime with one compare register; the interrupt lags the registers by one cycle
`timescale 1ns/1ps

module clint_timer import mem_hub_pkg::*; (
    input  logic  clk,
    input  logic  i_rst_n,
    input  logic  i_wr_en,
    input  logic  i_wr_cmp,
    input  word_t i_wr_data,
    output word_t o_mtime,
    output word_t o_mtimecmp,
    output logic  o_intr
);

    logic wr_mtime;
    logic wr_mtimecmp;

    // select picks mtimecmp when high, mtime when low
    assign wr_mtime    = i_wr_en && !i_wr_cmp;
    assign wr_mtimecmp = i_wr_en && i_wr_cmp;

    // mtime counts every cycle, a write loads it exactly
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_mtime <= '0;
        end else if (wr_mtime) begin
            o_mtime <= i_wr_data;
        end else begin
            o_mtime <= o_mtime + 64'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_mtimecmp <= '0;
        end else if (wr_mtimecmp) begin
            o_mtimecmp <= i_wr_data;
        end
    end

    // both registers reset to zero, so the compare already holds after reset
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_intr <= 1'b1;
        end else begin
            o_intr <= (o_mtime >= o_mtimecmp);
        end
    end

endmodule

// File: source/mem_request_fifo.sv
// Circular request queue; FIFO_DEPTH must be at least 2 and need not be a power of two
`timescale 1ns/1ps

module mem_request_fifo import mem_hub_pkg::*; #(
    parameter int FIFO_DEPTH = 2
) (
    input  logic  clk,
    input  logic  i_rst_n,
    input  logic  i_push,
    input  src_t  i_src,
    input  logic  i_we,
    input  addr_t i_addr,
    input  word_t i_wdata,
    output logic  o_full,
    input  logic  i_pop,
    output logic  o_not_empty,
    output src_t  o_src,
    output logic  o_we,
    output addr_t o_addr,
    output word_t o_wdata
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    src_t             src_mem   [FIFO_DEPTH];
    logic             we_mem    [FIFO_DEPTH];
    addr_t            addr_mem  [FIFO_DEPTH];
    word_t            wdata_mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // wrap at the last slot
    function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + PTR_W'(1);
    endfunction

    assign o_full      = (count == CNT_W'(FIFO_DEPTH));
    assign o_not_empty = (count != '0);
    assign do_push     = i_push && !o_full;
    assign do_pop      = i_pop && o_not_empty;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            if (do_push && !do_pop) begin
                count <= count + CNT_W'(1);
            end else if (do_pop && !do_push) begin
                count <= count - CNT_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            src_mem[wr_ptr]   <= i_src;
            we_mem[wr_ptr]    <= i_we;
            addr_mem[wr_ptr]  <= i_addr;
            wdata_mem[wr_ptr] <= i_wdata;
        end
    end

    // head entry
    assign o_src   = src_mem[rd_ptr];
    assign o_we    = we_mem[rd_ptr];
    assign o_addr  = addr_mem[rd_ptr];
    assign o_wdata = wdata_mem[rd_ptr];

    a_no_overflow: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_push |-> !o_full);
    a_no_underflow: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_pop |-> o_not_empty);

endmodule

// File: source/mem_bridge.sv
// Executes one queued request per cycle; RAM read data must be valid in the cycle its enable is high
`timescale 1ns/1ps

module mem_bridge import mem_hub_pkg::*; (
    input  logic  clk,
    input  logic  i_rst_n,
    input  logic  i_not_empty,
    input  src_t  i_src,
    input  logic  i_we,
    input  addr_t i_addr,
    input  word_t i_wdata,
    output logic  o_pop,
    output logic  o_read_inst_ena,
    output logic  o_read_ram_ena,
    output addr_t o_addr_outp,
    input  inst_t i_inst_data_in,
    input  word_t i_ram_data_in,
    output logic  o_write_ram_ena,
    output addr_t o_write_ram_addr,
    output word_t o_write_ram_data,
    output logic  o_resp_valid,
    output src_t  o_resp_src,
    output word_t o_resp_data,
    output logic  o_timer_intr
);

    logic  is_inst;
    logic  is_mtime;
    logic  is_mtimecmp;
    logic  is_timer;
    logic  timer_wr_en;
    word_t mtime;
    word_t mtimecmp;
    word_t rdata;

    // fetches always go to RAM, only data accesses see the timer
    assign is_inst     = (i_src == SRC_INST);
    assign is_mtime    = (i_addr == MTIME_ADDR);
    assign is_mtimecmp = (i_addr == MTIMECMP_ADDR);
    assign is_timer    = !is_inst && (is_mtime || is_mtimecmp);

    assign o_pop            = i_not_empty;
    assign o_read_inst_ena  = i_not_empty && is_inst;
    assign o_read_ram_ena   = i_not_empty && !is_inst && !is_timer && !i_we;
    assign o_write_ram_ena  = i_not_empty && !is_inst && !is_timer && i_we;
    assign o_addr_outp      = i_addr;
    assign o_write_ram_addr = i_addr;
    assign o_write_ram_data = i_wdata;
    assign timer_wr_en      = i_not_empty && is_timer && i_we;

    clint_timer timer0 (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_wr_en    (timer_wr_en),
        .i_wr_cmp   (is_mtimecmp),
        .i_wr_data  (i_wdata),
        .o_mtime    (mtime),
        .o_mtimecmp (mtimecmp),
        .o_intr     (o_timer_intr)
    );

    // read data select
    always_comb begin
        if (is_inst) begin
            rdata = {32'b0, i_inst_data_in};
        end else if (is_mtime) begin
            rdata = mtime;
        end else if (is_mtimecmp) begin
            rdata = mtimecmp;
        end else begin
            rdata = i_ram_data_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_resp_valid <= 1'b0;
        end else begin
            o_resp_valid <= i_not_empty;
        end
    end

    // writes answer too, the data is simply ignored by the arbiter's client
    always_ff @(posedge clk) begin
        if (i_not_empty) begin
            o_resp_src  <= i_src;
            o_resp_data <= rdata;
        end
    end

endmodule

// File: source/fetch_data_arbiter.sv
// One request at a time per client port; data wins a tie and only one push is in flight at once
`timescale 1ns/1ps

module fetch_data_arbiter import mem_hub_pkg::*; (
    input  logic  clk,
    input  logic  i_rst_n,
    input  logic  i_inst_req,
    input  addr_t i_inst_addr,
    output logic  o_inst_ack,
    output inst_t o_inst_data,
    input  logic  i_data_req,
    input  logic  i_data_we,
    input  addr_t i_data_addr,
    input  word_t i_data_wdata,
    output logic  o_data_ack,
    output word_t o_data_rdata,
    output logic  o_push,
    output src_t  o_push_src,
    output logic  o_push_we,
    output addr_t o_push_addr,
    output word_t o_push_wdata,
    input  logic  i_full,
    input  logic  i_resp_valid,
    input  src_t  i_resp_src,
    input  word_t i_resp_data
);

    port_state_e inst_state;
    port_state_e data_state;
    logic        can_push;
    logic        take_data;
    logic        take_inst;
    logic        inst_hit;
    logic        data_hit;

    function automatic port_state_e port_next(port_state_e cur, logic req, logic take,
                                              logic hit);
        port_state_e nxt;
        nxt = cur;
        case (cur)
            PORT_IDLE:   if (take) nxt = PORT_QUEUED;
            PORT_QUEUED: if (hit) nxt = PORT_ACK;
            PORT_ACK:    if (!req) nxt = PORT_IDLE;
            default:     nxt = PORT_IDLE;
        endcase
        return nxt;
    endfunction

    // full flag does not yet count a push still in flight, so wait for it to land
    assign can_push  = !o_push && !i_full;
    assign take_data = can_push && (data_state == PORT_IDLE) && i_data_req;
    assign take_inst = can_push && (inst_state == PORT_IDLE) && i_inst_req && !take_data;

    assign inst_hit = i_resp_valid && (i_resp_src == SRC_INST);
    assign data_hit = i_resp_valid && (i_resp_src == SRC_DATA);

    assign o_inst_ack = (inst_state == PORT_ACK);
    assign o_data_ack = (data_state == PORT_ACK);

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            inst_state <= PORT_IDLE;
            data_state <= PORT_IDLE;
            o_push     <= 1'b0;
        end else begin
            inst_state <= port_next(inst_state, i_inst_req, take_inst, inst_hit);
            data_state <= port_next(data_state, i_data_req, take_data, data_hit);
            o_push     <= take_data || take_inst;
        end
    end

    // request fields, held until the next winner
    always_ff @(posedge clk) begin
        if (take_data) begin
            o_push_src   <= SRC_DATA;
            o_push_we    <= i_data_we;
            o_push_addr  <= i_data_addr;
            o_push_wdata <= i_data_wdata;
        end else if (take_inst) begin
            o_push_src   <= SRC_INST;
            o_push_we    <= 1'b0;
            o_push_addr  <= i_inst_addr;
            o_push_wdata <= '0;
        end
    end

    // read data held for the whole ack phase
    always_ff @(posedge clk) begin
        if (inst_hit) begin
            o_inst_data <= i_resp_data[31:0];
        end
        if (data_hit) begin
            o_data_rdata <= i_resp_data;
        end
    end

    // queue must always have room for a registered push
    a_push_not_full: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_push |-> !i_full);

    // bridge answers only a port that is waiting on the queue
    a_inst_resp_queued: assert property (@(posedge clk) disable iff (!i_rst_n)
        inst_hit |-> inst_state == PORT_QUEUED);
    a_data_resp_queued: assert property (@(posedge clk) disable iff (!i_rst_n)
        data_hit |-> data_state == PORT_QUEUED);

endmodule

// File: source/soc_mem_hub.sv
// Four-phase client ports with one request each at a time; full 64-bit writes only; FIFO_DEPTH >= 2
`timescale 1ns/1ps

module soc_mem_hub import mem_hub_pkg::*; #(
    parameter int FIFO_DEPTH = 2
) (
    input  logic  clk,
    input  logic  i_rst_n,
    // instruction fetch port
    input  logic  i_inst_req,
    input  addr_t i_inst_addr,
    output logic  o_inst_ack,
    output inst_t o_inst_data,
    // data port
    input  logic  i_data_req,
    input  logic  i_data_we,
    input  addr_t i_data_addr,
    input  word_t i_data_wdata,
    output logic  o_data_ack,
    output word_t o_data_rdata,
    // external RAM
    output logic  o_read_inst_ena,
    output logic  o_read_ram_ena,
    output addr_t o_addr_outp,
    input  inst_t i_inst_data_in,
    input  word_t i_ram_data_in,
    output logic  o_write_ram_ena,
    output addr_t o_write_ram_addr,
    output word_t o_write_ram_data,
    output logic  o_timer_intr
);

    logic  push;
    src_t  push_src;
    logic  push_we;
    addr_t push_addr;
    word_t push_wdata;
    logic  fifo_full;
    logic  pop;
    logic  not_empty;
    src_t  head_src;
    logic  head_we;
    addr_t head_addr;
    word_t head_wdata;
    logic  resp_valid;
    src_t  resp_src;
    word_t resp_data;

    fetch_data_arbiter arbiter0 (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_inst_req   (i_inst_req),
        .i_inst_addr  (i_inst_addr),
        .o_inst_ack   (o_inst_ack),
        .o_inst_data  (o_inst_data),
        .i_data_req   (i_data_req),
        .i_data_we    (i_data_we),
        .i_data_addr  (i_data_addr),
        .i_data_wdata (i_data_wdata),
        .o_data_ack   (o_data_ack),
        .o_data_rdata (o_data_rdata),
        .o_push       (push),
        .o_push_src   (push_src),
        .o_push_we    (push_we),
        .o_push_addr  (push_addr),
        .o_push_wdata (push_wdata),
        .i_full       (fifo_full),
        .i_resp_valid (resp_valid),
        .i_resp_src   (resp_src),
        .i_resp_data  (resp_data)
    );

    mem_request_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo0 (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_push      (push),
        .i_src       (push_src),
        .i_we        (push_we),
        .i_addr      (push_addr),
        .i_wdata     (push_wdata),
        .o_full      (fifo_full),
        .i_pop       (pop),
        .o_not_empty (not_empty),
        .o_src       (head_src),
        .o_we        (head_we),
        .o_addr      (head_addr),
        .o_wdata     (head_wdata)
    );

    mem_bridge bridge0 (
        .clk              (clk),
        .i_rst_n          (i_rst_n),
        .i_not_empty      (not_empty),
        .i_src            (head_src),
        .i_we             (head_we),
        .i_addr           (head_addr),
        .i_wdata          (head_wdata),
        .o_pop            (pop),
        .o_read_inst_ena  (o_read_inst_ena),
        .o_read_ram_ena   (o_read_ram_ena),
        .o_addr_outp      (o_addr_outp),
        .i_inst_data_in   (i_inst_data_in),
        .i_ram_data_in    (i_ram_data_in),
        .o_write_ram_ena  (o_write_ram_ena),
        .o_write_ram_addr (o_write_ram_addr),
        .o_write_ram_data (o_write_ram_data),
        .o_resp_valid     (resp_valid),
        .o_resp_src       (resp_src),
        .o_resp_data      (resp_data),
        .o_timer_intr     (o_timer_intr)
    );

endmodule

// File: verification/tb_clock_gen.sv
// Free-running clock; the low-active reset is released 2 ns after the last reset edge
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            o_clk = ~o_clk;
        end
    end

    // reset held for RESET_CYCLES rising edges
    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #2;
        o_rst_n = 1'b1;
    end

endmodule

// File: verification/tb_soc_mem_hub.sv
// Runs with FIFO_DEPTH 2 and a 256-word RAM model on address bits [10:3]; stops at the first error
`timescale 1ns/1ps

module tb_soc_mem_hub
    import mem_hub_pkg::*;
();

    localparam int N_TRANS     = 300;
    localparam int CYCLES_PER  = 40;
    localparam int PERIOD_NS   = 20;
    localparam int WATCHDOG_NS = N_TRANS * CYCLES_PER * PERIOD_NS;

    logic  clk;
    logic  rst_n;
    logic  inst_req;
    addr_t inst_addr;
    logic  inst_ack;
    inst_t inst_data;
    logic  data_req;
    logic  data_we;
    addr_t data_addr;
    word_t data_wdata;
    logic  data_ack;
    word_t data_rdata;
    logic  read_inst_ena;
    logic  read_ram_ena;
    addr_t addr_outp;
    inst_t inst_data_in;
    word_t ram_data_in;
    logic  write_ram_ena;
    addr_t write_ram_addr;
    word_t write_ram_data;
    logic  timer_intr;

    word_t  ram [256];
    word_t  exp_mem [256];
    integer seed;
    word_t  exp_mtimecmp;
    word_t  mtime_floor;
    word_t  mtime_last_wr;
    logic   fetch_busy;
    addr_t  fetch_addr;
    logic   wr_busy;
    addr_t  wr_addr;
    word_t  wr_data;
    logic   rd_busy;
    addr_t  rd_addr;
    logic   ack_intr;
    int     inst_ena_count;
    int     wr_pulse_count;
    int     rd_pulse_count;
    logic   prev_inst_ack;
    logic   prev_inst_req;
    logic   prev_data_ack;
    logic   prev_data_req;

    tb_clock_gen #(
        .PERIOD_NS    (PERIOD_NS),
        .RESET_CYCLES (5)
    ) clkgen0 (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    soc_mem_hub #(
        .FIFO_DEPTH (2)
    ) dut0 (
        .clk              (clk),
        .i_rst_n          (rst_n),
        .i_inst_req       (inst_req),
        .i_inst_addr      (inst_addr),
        .o_inst_ack       (inst_ack),
        .o_inst_data      (inst_data),
        .i_data_req       (data_req),
        .i_data_we        (data_we),
        .i_data_addr      (data_addr),
        .i_data_wdata     (data_wdata),
        .o_data_ack       (data_ack),
        .o_data_rdata     (data_rdata),
        .o_read_inst_ena  (read_inst_ena),
        .o_read_ram_ena   (read_ram_ena),
        .o_addr_outp      (addr_outp),
        .i_inst_data_in   (inst_data_in),
        .i_ram_data_in    (ram_data_in),
        .o_write_ram_ena  (write_ram_ena),
        .o_write_ram_addr (write_ram_addr),
        .o_write_ram_data (write_ram_data),
        .o_timer_intr     (timer_intr)
    );

    // every word differs in both halves
    function automatic word_t fill_word(logic [7:0] idx);
        return {24'h5a5a5a, idx, 24'hc3c3c3, ~idx};
    endfunction

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic addr_t ram_addr(logic [7:0] idx);
        return 64'h8000_0000 | {53'd0, idx, 3'b000};
    endfunction

    task automatic finish_with_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input word_t got, input word_t exp);
        $display("CHECK FAILED at time %0t: %s got %h expected %h", $time, name, got, exp);
        finish_with_failure();
    endtask

    task automatic report_error(input string what);
        $display("ERROR at time %0t: %s", $time, what);
        finish_with_failure();
    endtask

    // RAM model, filled while reset is low
    assign ram_data_in  = ram[addr_outp[10:3]];
    assign inst_data_in = ram[addr_outp[10:3]][31:0];

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 256; i++) begin
                ram[i] <= fill_word(8'(i));
            end
        end else if (write_ram_ena) begin
            ram[write_ram_addr[10:3]] <= write_ram_data;
        end
    end

    // RAM port and handshake monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (read_inst_ena) begin
                assert (fetch_busy) else report_error("instruction read with no fetch pending");
                assert (addr_outp == fetch_addr)
                    else report_mismatch("o_addr_outp", addr_outp, fetch_addr);
                inst_ena_count++;
            end
            if (read_ram_ena) begin
                assert (rd_busy) else report_error("RAM read enable with no RAM read pending");
                assert (addr_outp == rd_addr)
                    else report_mismatch("o_addr_outp", addr_outp, rd_addr);
                rd_pulse_count++;
            end
            if (write_ram_ena) begin
                assert (wr_busy) else report_error("RAM write pulse with no RAM write pending");
                assert (write_ram_addr == wr_addr)
                    else report_mismatch("o_write_ram_addr", write_ram_addr, wr_addr);
                assert (write_ram_data == wr_data)
                    else report_mismatch("o_write_ram_data", write_ram_data, wr_data);
                wr_pulse_count++;
            end
            if (prev_inst_ack && !inst_ack) begin
                assert (!prev_inst_req) else report_error("o_inst_ack fell before its req fell");
            end
            if (prev_data_ack && !data_ack) begin
                assert (!prev_data_req) else report_error("o_data_ack fell before its req fell");
            end
        end
        prev_inst_ack = inst_ack;
        prev_inst_req = inst_req;
        prev_data_ack = data_ack;
        prev_data_req = data_req;
    end

    task automatic run_fetch(input logic [7:0] idx);
        word_t expected;
        int    waited;
        int    ena_start;
        expected = exp_mem[idx];
        @(posedge clk);
        #2;
        fetch_addr = ram_addr(idx);
        fetch_busy = 1'b1;
        ena_start  = inst_ena_count;
        inst_addr  = ram_addr(idx);
        inst_req   = 1'b1;
        waited     = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!inst_ack);
        assert (waited >= 4) else report_error("instruction ack came within four cycles of req");
        assert (inst_data == expected[31:0])
            else report_mismatch("o_inst_data", {32'd0, inst_data}, {32'd0, expected[31:0]});
        assert (inst_ena_count - ena_start == 1)
            else report_error("o_read_inst_ena not seen exactly once for the fetch");
        fetch_busy = 1'b0;
        @(posedge clk);
        #2;
        inst_req = 1'b0;
        do begin
            @(negedge clk);
        end while (inst_ack);
    endtask

    // one four-phase access on the data port
    task automatic data_access(input logic we, input addr_t addr, input word_t wdata,
                               input logic to_ram, output word_t rdata);
        int waited;
        int pulse_start;
        int read_start;
        @(posedge clk);
        #2;
        wr_busy     = to_ram && we;
        rd_busy     = to_ram && !we;
        wr_addr     = addr;
        wr_data     = wdata;
        rd_addr     = addr;
        pulse_start = wr_pulse_count;
        read_start  = rd_pulse_count;
        data_we     = we;
        data_addr   = addr;
        data_wdata  = wdata;
        data_req    = 1'b1;
        waited      = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!data_ack);
        assert (waited >= 4) else report_error("data ack came within four cycles of req");
        if (to_ram && we) begin
            assert (wr_pulse_count - pulse_start == 1)
                else report_error("RAM write did not pulse exactly once before its ack");
        end
        if (to_ram && !we) begin
            assert (rd_pulse_count - read_start == 1)
                else report_error("o_read_ram_ena not seen exactly once for the data read");
        end
        rdata    = data_rdata;
        ack_intr = timer_intr;
        wr_busy  = 1'b0;
        rd_busy  = 1'b0;
        @(posedge clk);
        #2;
        data_req = 1'b0;
        do begin
            @(negedge clk);
        end while (data_ack);
    endtask

    task automatic ram_write(input logic [7:0] idx, input word_t value);
        word_t unused;
        exp_mem[idx] = value;
        data_access(1'b1, ram_addr(idx), value, 1'b1, unused);
    endtask

    task automatic ram_read(input logic [7:0] idx);
        word_t expected;
        word_t got;
        expected = exp_mem[idx];
        data_access(1'b0, ram_addr(idx), '0, 1'b1, got);
        assert (got == expected) else report_mismatch("o_data_rdata", got, expected);
    endtask

    task automatic mtimecmp_write(input word_t value);
        word_t unused;
        exp_mtimecmp = value;
        data_access(1'b1, MTIMECMP_ADDR, value, 1'b0, unused);
    endtask

    task automatic mtimecmp_read();
        word_t got;
        data_access(1'b0, MTIMECMP_ADDR, '0, 1'b0, got);
        assert (got == exp_mtimecmp) else report_mismatch("mtimecmp read", got, exp_mtimecmp);
    endtask

    task automatic mtime_write(input word_t value);
        word_t unused;
        mtime_last_wr = value;
        mtime_floor   = value;
        data_access(1'b1, MTIME_ADDR, value, 1'b0, unused);
    endtask

    // mtime only moves forward from the last written value
    task automatic mtime_read();
        word_t got;
        data_access(1'b0, MTIME_ADDR, '0, 1'b0, got);
        assert (got >= mtime_last_wr) else report_mismatch("mtime read", got, mtime_last_wr);
        assert (got >= mtime_floor) else report_mismatch("mtime read", got, mtime_floor);
        mtime_floor = got;
    endtask

    initial begin
        #(WATCHDOG_NS);
        report_error("watchdog expired before the test sequence finished");
    end

    initial begin
        logic [31:0] rnd;
        logic [7:0]  op;
        logic [7:0]  idx_a;
        logic [7:0]  idx_b;
        word_t       value;
        seed           = 24;
        inst_req       = 1'b0;
        inst_addr      = '0;
        data_req       = 1'b0;
        data_we        = 1'b0;
        data_addr      = '0;
        data_wdata     = '0;
        fetch_busy     = 1'b0;
        fetch_addr     = '0;
        wr_busy        = 1'b0;
        wr_addr        = '0;
        wr_data        = '0;
        rd_busy        = 1'b0;
        rd_addr        = '0;
        inst_ena_count = 0;
        wr_pulse_count = 0;
        rd_pulse_count = 0;
        exp_mtimecmp   = '0;
        mtime_floor    = '0;
        mtime_last_wr  = '0;
        for (int i = 0; i < 256; i++) begin
            exp_mem[i] = fill_word(8'(i));
        end

        wait (rst_n);
        @(negedge clk);
        assert (!inst_ack && !data_ack) else report_error("an ack is high after reset");
        assert (!read_inst_ena && !read_ram_ena && !write_ram_ena)
            else report_error("a RAM enable is high after reset");
        assert (timer_intr) else report_mismatch("o_timer_intr", {63'd0, timer_intr}, 64'd1);

        for (int n = 0; n < N_TRANS; n++) begin
            rnd   = rand32();
            value = {rand32(), rand32()};
            idx_a = rnd[7:0];
            // fetch slot kept apart from the data slot
            idx_b = idx_a ^ (rnd[15:8] | 8'h01);
            op    = rnd[31:24] % 8'd6;
            case (op)
                8'd0: run_fetch(idx_a);
                8'd1: ram_write(idx_a, value);
                8'd2: ram_read(idx_a);
                8'd3: begin
                    fork
                        run_fetch(idx_b);
                        begin
                            if (rnd[16]) ram_write(idx_a, value);
                            else ram_read(idx_a);
                        end
                    join
                end
                8'd4: begin
                    if (rnd[17]) mtimecmp_write(value);
                    else mtimecmp_read();
                end
                default: begin
                    if (rnd[18]) mtime_write({32'd0, value[31:0]});
                    else mtime_read();
                end
            endcase
        end

        // interrupt off, then back on
        mtimecmp_write(64'd1 << 40);
        mtime_write(64'd0);
        assert (!ack_intr) else report_mismatch("o_timer_intr", {63'd0, ack_intr}, 64'd0);
        mtimecmp_write(64'd0);
        assert (ack_intr || timer_intr)
            else report_error("o_timer_intr not high within 2 cycles of the mtimecmp write ack");
        mtime_read();
        mtimecmp_read();

        repeat (2) @(negedge clk);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: sources.f
source/mem_hub_pkg.sv
source/clint_timer.sv
source/mem_request_fifo.sv
source/mem_bridge.sv
source/fetch_data_arbiter.sv
source/soc_mem_hub.sv
verification/tb_clock_gen.sv
verification/tb_soc_mem_hub.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the pass line.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_soc_mem_hub -f sources.f -o sim_soc_mem_hub

./obj_dir/sim_soc_mem_hub | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
